// File: kl10ebus.f
hw/kl10ebusPkg.sv
hw/ebusCtl.sv
hw/ebusMux.sv
hw/aprRegs.sv
hw/vmaRegs.sv
hw/mtrRegs.sv
hw/kl10ebus.sv
tb/kl10ebus_props.sv
tb/kl10ebusTb.sv

// File: Makefile
# Verilator simulation of the E-bus model

VERILATOR ?= verilator
TOP       ?= kl10ebusTb
FILELIST  ?= kl10ebus.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench, run it and check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q -- '^>>> PASS$$' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb/kl10ebusTb.sv
`timescale 1ns/1ps

module kl10ebusTb import kl10ebusPkg::*; ();

  localparam int nDrivers = 3;
  localparam int vmaWidth = 23;

  logic       clk;
  logic       rstN;
  logic       cmdStrobe;
  logic [2:0] cmdCs;
  logic [2:0] cmdFunc;
  ebusWord    cmdData;
  logic       vmaInc;
  logic       mtrTick;
  logic       rdValid;
  ebusWord    rdData;
  logic       aprIrq;
  logic       mtrHit;
  logic       busConflict;

  // shadow copy of every board register
  ebusWord             aprFlags;
  ebusWord             aprMask;
  ebusWord             mtrCount;
  ebusWord             mtrThresh;
  logic [vmaWidth-1:0] vmaAddr;
  logic [vmaWidth-1:0] vmaPrev;
  // command sampled on the previous edge, which loads registers on this edge
  tEbusSel             pending;
  ebusWord             expQ[$];
  int                  nChecks = 0;
  int                  nErrors = 0;
  int                  testBase = 0;

  kl10ebus #(.nDrivers(nDrivers), .vmaWidth(vmaWidth)) kl10ebus_i (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic ebusWord expectedRead(logic [2:0] cs, logic [2:0] func);
    ebusWord r;
    r = '0;
    if (func[1:0] == 2'd0) begin
      if (cs == csApr) r = aprFlags;
      if (cs == csVma) r = ebusWord'(vmaAddr);
      if (cs == csMtr) r = mtrCount;
    end else if (func[1:0] == 2'd1) begin
      if (cs == csApr) r = aprMask;
      if (cs == csVma) r = ebusWord'(vmaPrev);
      if (cs == csMtr) r = mtrThresh;
    end
    return r;
  endfunction

  task automatic compare(string what, ebusWord got, ebusWord exp);
    nChecks++;
    if (got !== exp) begin
      nErrors++;
      $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    end
  endtask

  // reference model, a load from the bus wins over a count on the same edge
  always @(posedge clk) begin
    logic       wr;
    logic [1:0] idx;
    if (!rstN) begin
      aprFlags  = '0;
      aprMask   = '0;
      mtrCount  = '0;
      mtrThresh = '0;
      vmaAddr   = '0;
      vmaPrev   = '0;
      pending   = '0;
    end else begin
      wr  = pending.active && pending.func[2];
      idx = pending.func[1:0];
      if (wr && pending.cs == csApr && idx == 2'd0) aprFlags = pending.wrData;
      if (wr && pending.cs == csApr && idx == 2'd1) aprMask = pending.wrData;
      if (wr && pending.cs == csVma && idx == 2'd0) begin
        vmaPrev = vmaAddr;
        vmaAddr = pending.wrData[vmaWidth-1:0];
      end else begin
        if (vmaInc) vmaAddr = vmaAddr + 1'b1;
        if (wr && pending.cs == csVma && idx == 2'd1) vmaPrev = pending.wrData[vmaWidth-1:0];
      end
      if (wr && pending.cs == csMtr && idx == 2'd0) begin
        mtrCount = pending.wrData;
      end else if (mtrTick) begin
        mtrCount = mtrCount + 1'b1;
      end
      if (wr && pending.cs == csMtr && idx == 2'd1) mtrThresh = pending.wrData;
      if (cmdStrobe && !cmdFunc[2]) expQ.push_back(expectedRead(cmdCs, cmdFunc));
      pending = '{active: cmdStrobe, cs: cmdCs, func: cmdFunc, wrData: cmdData};
    end
  end

  // outputs are settled by the falling edge
  always @(negedge clk) begin
    if (rstN) begin
      if (rdValid) begin
        if (expQ.size() == 0) begin
          nErrors++;
          $display("a read result arrived at %0t with no read outstanding", $time);
        end else begin
          compare("rdData", rdData, expQ.pop_front());
        end
      end
      compare("aprIrq", ebusWord'(aprIrq), ebusWord'(|(aprFlags & aprMask)));
      compare("mtrHit", ebusWord'(mtrHit),
              ebusWord'((mtrThresh != '0) && (mtrCount >= mtrThresh)));
      compare("busConflict", ebusWord'(busConflict), '0);
    end
  end

  task automatic step(logic strobe, logic [2:0] cs, logic [2:0] func, ebusWord data,
                      logic inc, logic tick);
    cmdStrobe = strobe;
    cmdCs     = cs;
    cmdFunc   = func;
    cmdData   = data;
    vmaInc    = inc;
    mtrTick   = tick;
    @(posedge clk);
    #1;
  endtask

  task automatic access(logic [2:0] cs, logic [2:0] func, ebusWord data);
    step(1'b1, cs, func, data, 1'b0, 1'b0);
  endtask

  task automatic idle();
    step(1'b0, 3'd0, 3'd0, '0, 1'b0, 1'b0);
  endtask

  function automatic ebusWord rndWord();
    logic [63:0] r;
    r = {$urandom, $urandom};
    return r[35:0];
  endfunction

  task automatic finishTest(string name);
    int waited;
    waited = 0;
    idle();
    while (expQ.size() != 0 && waited < 20) begin
      idle();
      waited++;
    end
    if (expQ.size() != 0) begin
      nErrors++;
      $display("timed out waiting for read results in test %s", name);
    end
    $display("test %s done with %0d errors", name, nErrors - testBase);
    testBase = nErrors;
  endtask

  initial begin
    logic [2:0] cs;
    void'($urandom(32'h2024ea4a));
    rstN      = 1'b0;
    cmdStrobe = 1'b0;
    cmdCs     = '0;
    cmdFunc   = '0;
    cmdData   = '0;
    vmaInc    = 1'b0;
    mtrTick   = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rstN = 1'b1;

    for (int c = 0; c < 3; c++) begin
      access(3'(c), funcRdReg0, '0);
      access(3'(c), funcRdReg1, '0);
    end
    finishTest("reset values");

    for (int k = 0; k < 24; k++) begin
      cs = 3'($urandom_range(2));
      access(cs, {2'b10, 1'($urandom_range(1))}, rndWord());
      access(cs, funcRdReg0, '0);
      access(cs, funcRdReg1, '0);
    end
    finishTest("write and read back");

    // start both counters at their top value so the random ticks wrap them
    access(csVma, funcWrReg0, '1);
    access(csMtr, funcWrReg0, '1);
    for (int k = 0; k < 60; k++) begin
      step(1'($urandom_range(1)), 3'($urandom_range(2)), 3'($urandom_range(1)), '0,
           1'($urandom_range(1)), 1'($urandom_range(1)));
    end
    access(csVma, funcWrReg0, 36'h123);
    step(1'b1, csVma, funcRdReg0, '0, 1'b1, 1'b0);
    access(csMtr, funcWrReg0, 36'd5);
    step(1'b1, csMtr, funcRdReg0, '0, 1'b0, 1'b1);
    finishTest("count pulses");

    for (int k = 0; k < 12; k++) begin
      access(csApr, funcWrReg0, rndWord() & rndWord() & rndWord());
      access(csApr, funcWrReg1, ebusWord'(1) << $urandom_range(35));
      idle();
    end
    access(csMtr, funcWrReg1, 36'd10);
    access(csMtr, funcWrReg0, 36'd8);
    repeat (4) step(1'b0, 3'd0, 3'd0, '0, 1'b0, 1'b1);
    access(csMtr, funcWrReg1, '0);
    finishTest("status outputs");

    for (int k = 0; k < 40; k++) begin
      access(3'($urandom_range(2)), {1'($urandom_range(1)), 1'b0, 1'($urandom_range(1))},
             rndWord());
    end
    finishTest("back to back");

    for (int c = 3; c < 8; c++) begin
      access(3'(c), funcRdReg0, '0);
      access(3'(c), funcRdReg1, '0);
    end
    finishTest("empty selects");

    if (expQ.size() != 0) begin
      nErrors++;
      $display("%0d expected read results never arrived", expQ.size());
    end
    $display("finished with %0d checks and %0d errors", nChecks, nErrors);
    if (nErrors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: tb/kl10ebus_props.sv
`timescale 1ns/1ps

// read timing of the controller and bus ownership at the multiplexer
module kl10ebus_props (
  input logic       clk,
  input logic       rstN,
  input logic       cmdStrobe,
  input logic [2:0] cmdFunc,
  input logic       rdValid,
  input logic       busConflict
);

  logic rdStrobe;

  assign rdStrobe = cmdStrobe && !cmdFunc[2];

  // a read sampled at one edge is answered right after the next edge
  rdFollowsStrobe: assert property (@(posedge clk) disable iff (!rstN)
    rdStrobe |-> ##2 rdValid)
    else $error("rdValid did not follow a read strobe");

  noStrayRd: assert property (@(posedge clk) disable iff (!rstN)
    rdValid |-> $past(rdStrobe, 2))
    else $error("rdValid without a read strobe before it");

  noConflict: assert property (@(posedge clk) disable iff (!rstN) !busConflict)
    else $error("more than one board drove the bus");

endmodule

bind kl10ebus kl10ebus_props props_i (
  .clk, .rstN, .cmdStrobe, .cmdFunc, .rdValid, .busConflict
);

// File: hw/kl10ebus.sv
`timescale 1ns/1ps

module kl10ebus import kl10ebusPkg::*; #(
  parameter int nDrivers = 3,
  parameter int vmaWidth = 23
) (
  input  logic       clk,
  input  logic       rstN,
  input  logic       cmdStrobe,
  input  logic [2:0] cmdCs,
  input  logic [2:0] cmdFunc,
  input  ebusWord    cmdData,
  input  logic       vmaInc,
  input  logic       mtrTick,
  output logic       rdValid,
  output ebusWord    rdData,
  output logic       aprIrq,
  output logic       mtrHit,
  output logic       busConflict
);

  tEbusSel    sel;
  ebusWord    ebus;
  // mux inputs in priority order, APR first
  tEbusDriver drivers [nDrivers];

  ebusCtl ebusCtl_i (
    .clk, .rstN, .cmdStrobe, .cmdCs, .cmdFunc, .cmdData,
    .sel, .ebus, .rdValid, .rdData
  );

  aprRegs aprRegs_i (.clk, .rstN, .sel, .drv(drivers[0]), .aprIrq);

  vmaRegs #(.vmaWidth(vmaWidth)) vmaRegs_i (
    .clk, .rstN, .sel, .vmaInc, .drv(drivers[1])
  );

  mtrRegs mtrRegs_i (.clk, .rstN, .sel, .mtrTick, .drv(drivers[2]), .mtrHit);

  ebusMux #(.nDrivers(nDrivers)) ebusMux_i (.drivers, .ebus, .busConflict);

endmodule

// File: hw/mtrRegs.sv
`timescale 1ns/1ps

module mtrRegs import kl10ebusPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  tEbusSel    sel,
  input  logic       mtrTick,
  output tEbusDriver drv,
  output logic       mtrHit
);

  ebusWord count;
  ebusWord threshold;
  logic    hit;
  logic    wrCount;

  assign hit     = selects(sel, csMtr);
  assign wrCount = hit && isWrite(sel.func) && (regIdx(sel.func) == 2'd0);

  // the event counter counts ticks unless software is loading it
  always_ff @(posedge clk) begin
    if (!rstN) begin
      count <= '0;
    end else if (wrCount) begin
      count <= sel.wrData;
    end else if (mtrTick) begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      threshold <= '0;
    end else if (hit && isWrite(sel.func) && (regIdx(sel.func) == 2'd1)) begin
      threshold <= sel.wrData;
    end
  end

  always_comb begin
    drv.driving = hit && !isWrite(sel.func);
    case (regIdx(sel.func))
      2'd0:    drv.data = count;
      2'd1:    drv.data = threshold;
      default: drv.data = '0;
    endcase
  end

  // a zero threshold means the meter is disarmed
  assign mtrHit = (threshold != '0) && (count >= threshold);

endmodule

// File: hw/vmaRegs.sv
`timescale 1ns/1ps

module vmaRegs import kl10ebusPkg::*; #(
  parameter int vmaWidth = 23
) (
  input  logic       clk,
  input  logic       rstN,
  input  tEbusSel    sel,
  input  logic       vmaInc,
  output tEbusDriver drv
);

  logic [vmaWidth-1:0] vma;
  logic [vmaWidth-1:0] prevVma;
  logic                hit;
  logic                wrVma;

  assign hit   = selects(sel, csVma);
  assign wrVma = hit && isWrite(sel.func) && (regIdx(sel.func) == 2'd0);

  // a bus load wins over a count on the same edge
  // the old address is kept in prevVma whenever a new one is loaded
  always_ff @(posedge clk) begin
    if (!rstN) begin
      vma     <= '0;
      prevVma <= '0;
    end else begin
      if (wrVma) begin
        vma     <= sel.wrData[vmaWidth-1:0];
        prevVma <= vma;
      end else begin
        if (vmaInc) begin
          vma <= vma + 1'b1;
        end
        if (hit && isWrite(sel.func) && (regIdx(sel.func) == 2'd1)) begin
          prevVma <= sel.wrData[vmaWidth-1:0];
        end
      end
    end
  end

  // both registers come back zero-extended to the full bus word
  always_comb begin
    drv.driving = hit && !isWrite(sel.func);
    case (regIdx(sel.func))
      2'd0:    drv.data = ebusWord'(vma);
      2'd1:    drv.data = ebusWord'(prevVma);
      default: drv.data = '0;
    endcase
  end

endmodule

// File: hw/aprRegs.sv
`timescale 1ns/1ps

module aprRegs import kl10ebusPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  tEbusSel    sel,
  output tEbusDriver drv,
  output logic       aprIrq
);

  ebusWord flags;
  ebusWord mask;
  logic    hit;

  assign hit = selects(sel, csApr);

  // register 0 holds the condition flags, register 1 the enable mask
  always_ff @(posedge clk) begin
    if (!rstN) begin
      flags <= '0;
      mask  <= '0;
    end else if (hit && isWrite(sel.func)) begin
      case (regIdx(sel.func))
        2'd0:    flags <= sel.wrData;
        2'd1:    mask  <= sel.wrData;
        default: ;
      endcase
    end
  end

  // reads drive the bus in the same cycle the select is held
  always_comb begin
    drv.driving = hit && !isWrite(sel.func);
    case (regIdx(sel.func))
      2'd0:    drv.data = flags;
      2'd1:    drv.data = mask;
      default: drv.data = '0;
    endcase
  end

  // an interrupt is requested by any flag that is also enabled
  assign aprIrq = |(flags & mask);

endmodule

// File: hw/ebusMux.sv
`timescale 1ns/1ps

module ebusMux import kl10ebusPkg::*; #(
  parameter int nDrivers = 3
) (
  input  tEbusDriver drivers [nDrivers],
  output ebusWord    ebus,
  output logic       busConflict
);

  // walk from the top down so the lowest index that drives wins
  always_comb begin
    ebus = '0;
    for (int i = nDrivers - 1; i >= 0; i--) begin
      if (drivers[i].driving) begin
        ebus = drivers[i].data;
      end
    end
  end

  // two boards answering the same command means a select decode is broken
  always_comb begin
    int nDriving;
    nDriving = 0;
    for (int i = 0; i < nDrivers; i++) begin
      if (drivers[i].driving) begin
        nDriving++;
      end
    end
    busConflict = (nDriving > 1);
  end

endmodule

// File: hw/ebusCtl.sv
`timescale 1ns/1ps

module ebusCtl import kl10ebusPkg::*; (
  input  logic       clk,
  input  logic       rstN,
  input  logic       cmdStrobe,
  input  logic [2:0] cmdCs,
  input  logic [2:0] cmdFunc,
  input  ebusWord    cmdData,
  output tEbusSel    sel,
  input  ebusWord    ebus,
  output logic       rdValid,
  output ebusWord    rdData
);

  // set while the command now on the bus is a read
  logic rdPending;

  // stage 1 puts the strobed command on the bus for exactly one cycle
  always_ff @(posedge clk) begin
    if (!rstN) begin
      sel.active <= 1'b0;
      rdPending  <= 1'b0;
    end else begin
      sel.active <= cmdStrobe;
      rdPending  <= cmdStrobe && !isWrite(cmdFunc);
    end
  end

  // the rest of the command is payload and only matters while active
  always_ff @(posedge clk) begin
    if (cmdStrobe) begin
      sel.cs     <= cmdCs;
      sel.func   <= cmdFunc;
      sel.wrData <= cmdData;
    end
  end

  // stage 2 samples whatever the addressed board put on the bus
  always_ff @(posedge clk) begin
    if (!rstN) begin
      rdValid <= 1'b0;
    end else begin
      rdValid <= rdPending;
    end
  end

  always_ff @(posedge clk) begin
    if (rdPending) begin
      rdData <= ebus;
    end
  end

endmodule

// File: hw/kl10ebusPkg.sv
package kl10ebusPkg;

  // one word of the internal E-bus, bits numbered 35 down to 0
  typedef logic [35:0] ebusWord;

  // what each board presents to the bus multiplexer
  typedef struct packed {
    logic    driving;
    ebusWord data;
  } tEbusDriver;

  // the command the controller holds on the bus for one cycle
  typedef struct packed {
    logic       active;
    logic [2:0] cs;
    logic [2:0] func;
    ebusWord    wrData;
  } tEbusSel;

  // controller selects of the boards that exist, all other codes are empty
  localparam logic [2:0] csApr = 3'd0;
  localparam logic [2:0] csVma = 3'd1;
  localparam logic [2:0] csMtr = 3'd2;

  // function codes, bit 2 marks a write and bits 1:0 pick the register
  localparam logic [2:0] funcRdReg0 = 3'b000;
  localparam logic [2:0] funcRdReg1 = 3'b001;
  localparam logic [2:0] funcWrReg0 = 3'b100;
  localparam logic [2:0] funcWrReg1 = 3'b101;

  function automatic logic isWrite(logic [2:0] func);
    return func[2];
  endfunction

  function automatic logic [1:0] regIdx(logic [2:0] func);
    return func[1:0];
  endfunction

  // true while the held command is addressed to the given board
  function automatic logic selects(tEbusSel s, logic [2:0] cs);
    return s.active && (s.cs == cs);
  endfunction

endpackage
